// File: filelist.f
source/ifu_geom_pkg.sv
source/ifu_err_pkg.sv
source/asi_access_if.sv
source/stage_pipe.sv
source/ic_tag_check.sv
source/err_addr_file.sv
source/asi_regs.sv
source/asi_port.sv
source/ifu_err_dp.sv
dv/ifu_err_dp_assert.sv
dv/ifu_err_dp_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the fetch error datapath testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -sv -Wno-fatal \
   -f filelist.f --top-module ifu_err_dp_tb -Mdir obj_dir -o ifu_err_dp_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/ifu_err_dp_sim +verilator+error+limit+1000 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "Simulation passed" "$log"; then
   exit 0
fi
exit 1

// File: dv/ifu_err_dp_tb.sv
// testbench for the fetch error datapath
// clock, reset, directed and random stimulus, per-test report
`timescale 1ns/100ps

module ifu_err_dp_tb;
   import ifu_geom_pkg::*;
   import ifu_err_pkg::*;

   // cycles to wait for ldxa_valid
   localparam int valid_wait = 8;

   logic                 rclk;
   logic                 rst_n;
   ic_tag_t [n_ways-1:0] ic_tags;
   logic [n_ways-1:0]    ic_valid;
   pc_t                  fetch_pc;
   logic                 err_log;
   thread_t              err_thread;
   err_src_t             err_src;
   logic [irf_w-1:0]     irf_reg;
   logic [irf_w-1:0]     irf_synd;
   ea_t                  lsu_err_addr;
   logic                 asi_rd;
   logic                 asi_wr;
   asi_sel_t             asi_sel;
   thread_t              asi_idx;
   logic [ldxa_w-1:0]    asi_wdata;
   logic [ldxa_w-1:0]    ldxa_data;
   logic                 ldxa_valid;
   logic [n_ways-1:0]    tag_pe;
   logic [imask_w-1:0]   imask;
   int                   tests_done;
   int                   timeouts;

   ifu_err_dp dut0 (.*);

   initial begin
      rclk = 1'b0;
      forever #10 rclk = ~rclk;
   end

   // ----------------------------------------
   // stimulus helpers
   // ----------------------------------------
   // inputs change 2 ns after the edge
   task automatic next_cycle();
      @(posedge rclk);
      #2;
   endtask

   function automatic logic [63:0] rand_word();
      return {$urandom, $urandom};
   endfunction

   task automatic new_tags();
      logic [31:0] r;
      for (int w = 0; w < n_ways; w++) begin
         r = $urandom;
         ic_tags[w] = r[tag_w-1:0];
      end
      r = $urandom;
      ic_valid = r[n_ways-1:0];
   endtask

   // fresh fetch pc every cycle
   task automatic advance_pc(input int n);
      logic [63:0] r;
      for (int i = 0; i < n; i++) begin
         r = rand_word();
         fetch_pc = r[pc_w-1:0];
         next_cycle();
      end
   endtask

   task automatic asi_write(input asi_sel_t sel, input thread_t idx,
                            input logic [ldxa_w-1:0] data);
      asi_wr    = 1'b1;
      asi_sel   = sel;
      asi_idx   = idx;
      asi_wdata = data;
      next_cycle();
      asi_wr = 1'b0;
   endtask

   task automatic asi_read(input asi_sel_t sel, input thread_t idx);
      int waited;
      asi_rd  = 1'b1;
      asi_sel = sel;
      asi_idx = idx;
      next_cycle();
      asi_rd = 1'b0;
      waited = 0;
      while (!ldxa_valid && waited < valid_wait) begin
         next_cycle();
         waited++;
      end
      if (!ldxa_valid) begin
         $display("timeout: no ldxa_valid after an asi read at %0t", $time);
         timeouts++;
      end
   endtask

   task automatic log_error(input err_src_t src, input thread_t thr);
      logic [63:0] r;
      r            = rand_word();
      err_log      = 1'b1;
      err_src      = src;
      err_thread   = thr;
      irf_reg      = r[7:0];
      irf_synd     = r[15:8];
      lsu_err_addr = ea_t'(rand_word());
      fetch_pc     = pc_t'(rand_word());
      next_cycle();
      err_log = 1'b0;
   endtask

   task automatic end_test(input string name);
      tests_done++;
      $display("test %0d %s finished, assertion failures %0d",
               tests_done, name, dut0.u_chk.fail_cnt);
   endtask

   // ----------------------------------------
   // test sequence
   // ----------------------------------------
   initial begin
      void'($urandom(32'hb3a3_d5f0));
      rst_n        = 1'b0;
      ic_tags      = '0;
      ic_valid     = '0;
      fetch_pc     = '0;
      err_log      = 1'b0;
      err_thread   = '0;
      err_src      = src_irf;
      irf_reg      = '0;
      irf_synd     = '0;
      lsu_err_addr = '0;
      asi_rd       = 1'b0;
      asi_wr       = 1'b0;
      asi_sel      = sel_tag;
      asi_idx      = '0;
      asi_wdata    = '0;
      tests_done   = 0;
      timeouts     = 0;
      repeat (8) @(posedge rclk);
      #2;
      rst_n = 1'b1;
      next_cycle();

      // reset state, one valid per read, back to back
      asi_read(sel_imask, 2'd0);
      asi_read(sel_erren, 2'd0);
      asi_read(sel_err_addr, 2'd2);
      asi_read(sel_tag, 2'd1);
      end_test("reset_and_read_valid");

      // parity report off, then on
      asi_write(sel_erren, 2'd0, rand_word() & ~64'h1);
      for (int i = 0; i < 8; i++) begin
         new_tags();
         next_cycle();
      end
      asi_write(sel_erren, 2'd0, rand_word() | 64'h1);
      for (int i = 0; i < 16; i++) begin
         new_tags();
         next_cycle();
      end
      asi_read(sel_erren, 2'd0);
      end_test("tag_parity_enable");

      for (int i = 0; i < 3; i++) begin
         asi_write(sel_imask, 2'd0, rand_word());
         asi_read(sel_imask, 2'd0);
      end
      // mask write beside a read leaves the mask alone
      asi_rd    = 1'b1;
      asi_wr    = 1'b1;
      asi_sel   = sel_imask;
      asi_idx   = 2'd0;
      asi_wdata = rand_word();
      next_cycle();
      asi_rd = 1'b0;
      asi_wr = 1'b0;
      asi_read(sel_imask, 2'd0);
      end_test("imask_write_read");

      // every source into every thread
      for (int t = 0; t < n_threads; t++) begin
         for (int s = 0; s < 3; s++) begin
            advance_pc(2);
            log_error(err_src_t'(s), thread_t'(t));
            asi_read(sel_err_addr, thread_t'(t));
         end
      end
      end_test("error_log_sources");

      // write and log on one thread in one cycle
      for (int t = 0; t < n_threads; t++) begin
         asi_wr       = 1'b1;
         asi_sel      = sel_err_addr;
         asi_idx      = thread_t'(t);
         asi_wdata    = rand_word();
         err_log      = 1'b1;
         err_thread   = thread_t'(t);
         err_src      = src_lsu;
         lsu_err_addr = ea_t'(rand_word());
         next_cycle();
         asi_wr  = 1'b0;
         err_log = 1'b0;
         asi_read(sel_err_addr, thread_t'(t));
      end
      end_test("write_over_log");

      // tags keep moving so the read shows the staged set
      for (int w = 0; w < n_ways; w++) begin
         new_tags();
         next_cycle();
         new_tags();
         asi_read(sel_tag, thread_t'(w));
      end
      end_test("tag_read");

      next_cycle();
      next_cycle();
      $display("tests run %0d, assertion failures %0d, timeouts %0d",
               tests_done, dut0.u_chk.fail_cnt, timeouts);
      if (dut0.u_chk.fail_cnt == 0 && timeouts == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// File: dv/ifu_err_dp_assert.sv
// bound port checks for the fetch error datapath
// reference state for enables, mask, error addresses, pc history and staged tags
`timescale 1ns/100ps

module ifu_err_dp_assert (
   input logic                                              rclk,
   input logic                                              rst_n,
   input ifu_geom_pkg::ic_tag_t [ifu_geom_pkg::n_ways-1:0]  ic_tags,
   input logic [ifu_geom_pkg::n_ways-1:0]                   ic_valid,
   input ifu_geom_pkg::pc_t                                 fetch_pc,
   input logic                                              err_log,
   input ifu_geom_pkg::thread_t                             err_thread,
   input ifu_err_pkg::err_src_t                             err_src,
   input logic [ifu_err_pkg::irf_w-1:0]                     irf_reg,
   input logic [ifu_err_pkg::irf_w-1:0]                     irf_synd,
   input ifu_geom_pkg::ea_t                                 lsu_err_addr,
   input logic                                              asi_rd,
   input logic                                              asi_wr,
   input ifu_err_pkg::asi_sel_t                             asi_sel,
   input ifu_geom_pkg::thread_t                             asi_idx,
   input logic [ifu_err_pkg::ldxa_w-1:0]                    asi_wdata,
   input logic [ifu_err_pkg::ldxa_w-1:0]                    ldxa_data,
   input logic                                              ldxa_valid,
   input logic [ifu_geom_pkg::n_ways-1:0]                   tag_pe,
   input logic [ifu_geom_pkg::imask_w-1:0]                  imask
);
   import ifu_geom_pkg::*;
   import ifu_err_pkg::*;

   // failures so far, the testbench reads this
   int unsigned fail_cnt = 0;

   ic_tag_t [n_ways-1:0] tags_q;
   logic [n_ways-1:0]    vld_q;
   logic [n_ways-1:0]    in_par;
   logic [erren_w-1:0]   erren_q;
   logic [imask_w-1:0]   imask_q;
   ea_t                  eaddr_q [n_threads];
   ea_t                  pc_h1;
   ea_t                  pc_h2;
   ea_t                  log_val;
   logic                 asi_w;
   logic [ldxa_w-1:0]    exp_word;

   // a write beside a read does not count
   assign asi_w = asi_wr && !asi_rd;

   // odd parity of the incoming tags
   always_comb begin
      for (int w = 0; w < n_ways; w++) begin
         in_par[w] = ^ic_tags[w];
      end
   end

   // ----------------------------------------
   // expected log record
   // ----------------------------------------
   always_comb begin
      log_val = '0;
      if (err_src == src_irf) begin
         log_val[19:12] = irf_synd;
         log_val[7:0]   = irf_reg;
      end else if (err_src == src_lsu) begin
         log_val = lsu_err_addr;
      end else begin
         // pc two cycles before the strobe
         log_val = pc_h2;
      end
   end

   // ----------------------------------------
   // reference registers
   // ----------------------------------------
   always_ff @(posedge rclk or negedge rst_n) begin
      if (!rst_n) begin
         tags_q  <= '0;
         vld_q   <= '0;
         erren_q <= '0;
         imask_q <= '0;
         pc_h1   <= '0;
         pc_h2   <= '0;
         for (int t = 0; t < n_threads; t++) begin
            eaddr_q[t] <= '0;
         end
      end else begin
         tags_q <= ic_tags;
         vld_q  <= ic_valid;
         pc_h1  <= fetch_pc[47:4];
         pc_h2  <= pc_h1;
         if (asi_w && asi_sel == sel_erren) begin
            erren_q <= asi_wdata[1:0];
         end
         if (asi_w && asi_sel == sel_imask) begin
            imask_q <= asi_wdata[38:0];
         end
         if (err_log && err_src inside {src_irf, src_lsu, src_pc}) begin
            eaddr_q[err_thread] <= log_val;
         end
         // later assignment, so the write wins
         if (asi_w && asi_sel == sel_err_addr) begin
            eaddr_q[asi_idx] <= asi_wdata[47:4];
         end
      end
   end

   // expected load word for the current selector
   always_comb begin
      exp_word = '0;
      case (asi_sel)
         sel_tag: begin
            exp_word[31]   = vld_q[asi_idx];
            exp_word[28]   = ^tags_q[asi_idx];
            exp_word[27:0] = tags_q[asi_idx];
         end
         sel_err_addr: exp_word[47:4] = eaddr_q[asi_idx];
         sel_imask:    exp_word[38:0] = imask_q;
         default:      exp_word[1:0]  = erren_q;
      endcase
   end

   // ----------------------------------------
   // checks
   // ----------------------------------------
   reset_zero: assert property (@(posedge rclk)
      !rst_n |-> (!ldxa_valid && tag_pe == '0 && imask == '0))
      else begin
         fail_cnt++;
         $error("mismatch at %0t: outputs not zero under reset", $time);
      end

   rd_valid: assert property (@(posedge rclk) disable iff (!rst_n)
      asi_rd |=> ldxa_valid)
      else begin
         fail_cnt++;
         $error("mismatch at %0t: ldxa_valid missing after asi_rd", $time);
      end

   idle_valid: assert property (@(posedge rclk) disable iff (!rst_n)
      !asi_rd |=> !ldxa_valid)
      else begin
         fail_cnt++;
         $error("mismatch at %0t: ldxa_valid without a read", $time);
      end

   rd_data: assert property (@(posedge rclk) disable iff (!rst_n)
      asi_rd |=> (ldxa_data == $past(exp_word)))
      else begin
         fail_cnt++;
         $error("mismatch at %0t: ldxa_data %h", $time, ldxa_data);
      end

   // one stage behind the tags, gated by the correctable enable
   tag_parity: assert property (@(posedge rclk) disable iff (!rst_n)
      tag_pe == ($past(in_par) & {n_ways{erren_q[0]}}))
      else begin
         fail_cnt++;
         $error("mismatch at %0t: tag_pe %b", $time, tag_pe);
      end

   mask_out: assert property (@(posedge rclk) disable iff (!rst_n)
      imask == imask_q)
      else begin
         fail_cnt++;
         $error("mismatch at %0t: imask %h", $time, imask);
      end

endmodule

bind ifu_err_dp ifu_err_dp_assert u_chk (.*);

// File: source/ifu_err_dp.sv
// fetch error datapath top
// tag parity, error-address file, mask and enables, asi port
`timescale 1ns/100ps

module ifu_err_dp (
   input  logic                                        rclk,
   input  logic                                        rst_n,
   // fetch side
   input  ifu_geom_pkg::ic_tag_t [ifu_geom_pkg::n_ways-1:0] ic_tags,
   input  logic [ifu_geom_pkg::n_ways-1:0]             ic_valid,
   input  ifu_geom_pkg::pc_t                           fetch_pc,
   // error logging
   input  logic                                        err_log,
   input  ifu_geom_pkg::thread_t                       err_thread,
   input  ifu_err_pkg::err_src_t                       err_src,
   input  logic [ifu_err_pkg::irf_w-1:0]               irf_reg,
   input  logic [ifu_err_pkg::irf_w-1:0]               irf_synd,
   input  ifu_geom_pkg::ea_t                           lsu_err_addr,
   // asi access
   input  logic                                        asi_rd,
   input  logic                                        asi_wr,
   input  ifu_err_pkg::asi_sel_t                       asi_sel,
   input  ifu_geom_pkg::thread_t                       asi_idx,
   input  logic [ifu_err_pkg::ldxa_w-1:0]              asi_wdata,
   // outputs
   output logic [ifu_err_pkg::ldxa_w-1:0]              ldxa_data,
   output logic                                        ldxa_valid,
   output logic [ifu_geom_pkg::n_ways-1:0]             tag_pe,
   output logic [ifu_geom_pkg::imask_w-1:0]            imask
);
   import ifu_geom_pkg::*;
   import ifu_err_pkg::*;

   // ----------------------------------------
   // internal wiring
   // ----------------------------------------
   logic [erren_w-1:0] erren;
   logic [31:0]        tag_rd_word;
   ea_t                eaddr_rd;

   // decoded asi writes
   asi_access_if wr_if ();

   asi_port u_asi_port (
      .rclk        (rclk),
      .rst_n       (rst_n),
      .asi_rd      (asi_rd),
      .asi_wr      (asi_wr),
      .asi_sel     (asi_sel),
      .asi_idx     (asi_idx),
      .asi_wdata   (asi_wdata),
      .ctl         (wr_if.ctl),
      .tag_rd_word (tag_rd_word),
      .eaddr_rd    (eaddr_rd),
      .erren       (erren),
      .imask       (imask),
      .ldxa_data   (ldxa_data),
      .ldxa_valid  (ldxa_valid)
   );

   asi_regs u_asi_regs (
      .rclk  (rclk),
      .rst_n (rst_n),
      .wr    (wr_if.tgt),
      .erren (erren),
      .imask (imask)
   );

   // asi index names a way on tag reads
   ic_tag_check u_ic_tag_check (
      .rclk        (rclk),
      .rst_n       (rst_n),
      .ic_tags     (ic_tags),
      .ic_valid    (ic_valid),
      .ce_en       (erren[erren_ce]),
      .rd_way      (way_t'(asi_idx)),
      .tag_pe      (tag_pe),
      .tag_rd_word (tag_rd_word)
   );

   // and a thread on error-address reads
   err_addr_file u_err_addr_file (
      .rclk         (rclk),
      .rst_n        (rst_n),
      .wr           (wr_if.tgt),
      .err_log      (err_log),
      .err_thread   (err_thread),
      .err_src      (err_src),
      .irf_reg      (irf_reg),
      .irf_synd     (irf_synd),
      .lsu_err_addr (lsu_err_addr),
      .fetch_pc     (fetch_pc),
      .rd_thread    (asi_idx),
      .eaddr_rd     (eaddr_rd)
   );

endmodule

// File: source/asi_port.sv
// asi access decode and registered load return
// write strobes out on the interface, read word one cycle later
`timescale 1ns/100ps

module asi_port (
   input  logic                                 rclk,
   input  logic                                 rst_n,
   input  logic                                 asi_rd,
   input  logic                                 asi_wr,
   input  ifu_err_pkg::asi_sel_t                asi_sel,
   input  ifu_geom_pkg::thread_t                asi_idx,
   input  logic [ifu_err_pkg::ldxa_w-1:0]       asi_wdata,
   asi_access_if.ctl                            ctl,
   input  logic [31:0]                          tag_rd_word,
   input  ifu_geom_pkg::ea_t                    eaddr_rd,
   input  logic [ifu_err_pkg::erren_w-1:0]      erren,
   input  logic [ifu_geom_pkg::imask_w-1:0]     imask,
   output logic [ifu_err_pkg::ldxa_w-1:0]       ldxa_data,
   output logic                                 ldxa_valid
);
   import ifu_geom_pkg::*;
   import ifu_err_pkg::*;

   logic              wr_ok;
   logic [ldxa_w-1:0] rd_word;

   // ----------------------------------------
   // write decode
   // ----------------------------------------
   // read has priority, a write beside it is dropped
   assign wr_ok = asi_wr & ~asi_rd;

   assign ctl.wr_imask  = wr_ok && (asi_sel == sel_imask);
   assign ctl.wr_erren  = wr_ok && (asi_sel == sel_erren);
   assign ctl.wr_eaddr  = wr_ok && (asi_sel == sel_err_addr);
   assign ctl.wr_thread = asi_idx;
   assign ctl.wdata     = asi_wdata;

   // ----------------------------------------
   // read select and format
   // ----------------------------------------
   always_comb begin
      rd_word = '0;
      case (asi_sel)
         sel_tag:      rd_word[31:0] = tag_rd_word;
         // address goes back where it was written, 47..4
         sel_err_addr: rd_word[pc_w-1:pc_w-ea_w] = eaddr_rd;
         sel_imask:    rd_word[imask_w-1:0] = imask;
         sel_erren:    rd_word[erren_w-1:0] = erren;
         default:      rd_word = '0;
      endcase
   end

   // valid pulses for one cycle per read
   always_ff @(posedge rclk or negedge rst_n) begin
      if (!rst_n) begin
         ldxa_valid <= 1'b0;
      end else begin
         ldxa_valid <= asi_rd;
      end
   end

   // data only meaningful under valid
   always_ff @(posedge rclk) begin
      if (asi_rd) begin
         ldxa_data <= rd_word;
      end
   end

endmodule

// File: source/asi_regs.sv
// error enables and instruction mask, both asi writable
`timescale 1ns/100ps

module asi_regs (
   input  logic                                 rclk,
   input  logic                                 rst_n,
   asi_access_if.tgt                            wr,
   output logic [ifu_err_pkg::erren_w-1:0]      erren,
   output logic [ifu_geom_pkg::imask_w-1:0]     imask
);
   import ifu_geom_pkg::*;
   import ifu_err_pkg::*;

   // ----------------------------------------
   // enables
   // ----------------------------------------
   // bit 0 steers the tag parity report
   always_ff @(posedge rclk or negedge rst_n) begin
      if (!rst_n) begin
         erren <= '0;
      end else if (wr.wr_erren) begin
         erren <= wr.wdata[erren_w-1:0];
      end
   end

   // ----------------------------------------
   // instruction mask
   // ----------------------------------------
   // whole mask clears on reset
   always_ff @(posedge rclk or negedge rst_n) begin
      if (!rst_n) begin
         imask <= '0;
      end else if (wr.wr_imask) begin
         imask <= wr.wdata[imask_w-1:0];
      end
   end

endmodule

// File: source/err_addr_file.sv
// per-thread error-address registers
// log source select, pc history and asi write override
`timescale 1ns/100ps

module err_addr_file (
   input  logic                             rclk,
   input  logic                             rst_n,
   asi_access_if.tgt                        wr,
   input  logic                             err_log,
   input  ifu_geom_pkg::thread_t            err_thread,
   input  ifu_err_pkg::err_src_t            err_src,
   input  logic [ifu_err_pkg::irf_w-1:0]    irf_reg,
   input  logic [ifu_err_pkg::irf_w-1:0]    irf_synd,
   input  ifu_geom_pkg::ea_t                lsu_err_addr,
   input  ifu_geom_pkg::pc_t                fetch_pc,
   input  ifu_geom_pkg::thread_t            rd_thread,
   output ifu_geom_pkg::ea_t                eaddr_rd
);
   import ifu_geom_pkg::*;
   import ifu_err_pkg::*;

   ea_t  pc_d2;
   ea_t  log_rec;
   logic log_ok;
   ea_t  eaddr [n_threads];

   // ----------------------------------------
   // fetch pc history
   // ----------------------------------------
   // two stages back, only bits 47..4 kept
   stage_pipe #(
      .T     (ea_t),
      .depth (2)
   ) u_pc_pipe (
      .rclk  (rclk),
      .rst_n (rst_n),
      .d     (fetch_pc[pc_w-1:pc_w-ea_w]),
      .q     (pc_d2)
   );

   // ----------------------------------------
   // log record
   // ----------------------------------------
   always_comb begin
      log_rec = '0;
      log_ok  = 1'b1;
      case (err_src)
         src_irf: begin
            // syndrome at 19..12, register number at 7..0
            log_rec[irf_synd_lsb +: irf_w] = irf_synd;
            log_rec[irf_w-1:0]             = irf_reg;
         end
         src_lsu: log_rec = lsu_err_addr;
         src_pc:  log_rec = pc_d2;
         // unused encoding, nothing logged
         default: log_ok = 1'b0;
      endcase
   end

   // ----------------------------------------
   // address registers
   // ----------------------------------------
   // asi write beats a log to the same thread
   always_ff @(posedge rclk or negedge rst_n) begin
      if (!rst_n) begin
         for (int t = 0; t < n_threads; t++) begin
            eaddr[t] <= '0;
         end
      end else begin
         for (int t = 0; t < n_threads; t++) begin
            if (wr.wr_eaddr && wr.wr_thread == thread_t'(t)) begin
               eaddr[t] <= wr.wdata[pc_w-1:pc_w-ea_w];
            end else if (err_log && log_ok && err_thread == thread_t'(t)) begin
               eaddr[t] <= log_rec;
            end
         end
      end
   end

   // read port for the asi mux
   assign eaddr_rd = eaddr[rd_thread];

endmodule

// File: source/ic_tag_check.sv
// icache tag parity check, one stage behind the tag read
// also builds the tag word for an asi read of one way
`timescale 1ns/100ps

module ic_tag_check (
   input  logic                                        rclk,
   input  logic                                        rst_n,
   input  ifu_geom_pkg::ic_tag_t [ifu_geom_pkg::n_ways-1:0] ic_tags,
   input  logic [ifu_geom_pkg::n_ways-1:0]             ic_valid,
   input  logic                                        ce_en,
   input  ifu_geom_pkg::way_t                          rd_way,
   output logic [ifu_geom_pkg::n_ways-1:0]             tag_pe,
   output logic [31:0]                                 tag_rd_word
);
   import ifu_geom_pkg::*;

   // tags and valid bits travel together through one stage
   typedef struct packed {
      logic [n_ways-1:0]    vld;
      ic_tag_t [n_ways-1:0] tag;
   } tag_stage_t;

   tag_stage_t tags_f;
   tag_stage_t tags_s1;
   logic [n_ways-1:0] way_par;

   assign tags_f.vld = ic_valid;
   assign tags_f.tag = ic_tags;

   stage_pipe #(
      .T     (tag_stage_t),
      .depth (1)
   ) u_tag_pipe (
      .rclk  (rclk),
      .rst_n (rst_n),
      .d     (tags_f),
      .q     (tags_s1)
   );

   // ----------------------------------------
   // parity per way
   // ----------------------------------------
   // tag carries even parity, so odd means a flipped bit
   always_comb begin
      for (int w = 0; w < n_ways; w++) begin
         way_par[w] = ^tags_s1.tag[w];
      end
   end

   // only reported while correctable errors are on
   assign tag_pe = way_par & {n_ways{ce_en}};

   // asi view: valid at 31, parity at 28, tag below
   // raw parity here, not gated by the enable
   assign tag_rd_word = {tags_s1.vld[rd_way],
                         2'b00,
                         way_par[rd_way],
                         tags_s1.tag[rd_way]};

endmodule

// File: source/stage_pipe.sv
// staging flops of fixed depth for any packed payload
`timescale 1ns/100ps

module stage_pipe #(
   parameter type T     = logic,
   parameter int  depth = 1
) (
   input  logic rclk,
   input  logic rst_n,
   input  T     d,
   output T     q
);

   // stg[0] is the youngest stage
   T stg [depth];

   always_ff @(posedge rclk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < depth; i++) begin
            stg[i] <= '0;
         end
      end else begin
         stg[0] <= d;
         // shift toward the output
         for (int i = 1; i < depth; i++) begin
            stg[i] <= stg[i-1];
         end
      end
   end

   assign q = stg[depth-1];

endmodule

// File: source/asi_access_if.sv
// decoded asi write, from the asi port to the register owners
`timescale 1ns/100ps

interface asi_access_if ();
   import ifu_geom_pkg::*;
   import ifu_err_pkg::*;

   // one-cycle write strobes, never two at once
   logic              wr_imask;
   logic              wr_erren;
   logic              wr_eaddr;
   // target thread of an error-address write
   thread_t           wr_thread;
   // raw store data
   logic [ldxa_w-1:0] wdata;

   // decoder side
   modport ctl (output wr_imask, wr_erren, wr_eaddr, wr_thread, wdata);
   // register side
   modport tgt (input wr_imask, wr_erren, wr_eaddr, wr_thread, wdata);

endinterface

// File: source/ifu_err_pkg.sv
// error-reporting encodings of the fetch unit
// asi selector, error source and record field widths

package ifu_err_pkg;

   // ----------------------------------------
   // asi register selector
   // ----------------------------------------
   // tag read, per-thread error address, mask, enables
   typedef enum logic [1:0] {
      sel_tag      = 2'd0,
      sel_err_addr = 2'd1,
      sel_imask    = 2'd2,
      sel_erren    = 2'd3
   } asi_sel_t;

   // ----------------------------------------
   // error-address source
   // ----------------------------------------
   // 2'd3 is not a source; nothing gets logged for it
   typedef enum logic [1:0] {
      src_irf = 2'd0,
      src_lsu = 2'd1,
      src_pc  = 2'd2
   } err_src_t;

   // ----------------------------------------
   // record widths
   // ----------------------------------------
   // enable pair, bit 0 correctable and bit 1 uncorrectable
   localparam int erren_w  = 2;
   localparam int erren_ce = 0;
   // irf register number and ecc syndrome
   localparam int irf_w        = 8;
   // syndrome sits at 19..12 of the irf record
   localparam int irf_synd_lsb = 12;
   // asi load return width
   localparam int ldxa_w   = 64;

endpackage

// File: source/ifu_geom_pkg.sv
// fetch-side geometry of the error datapath
// thread, way, tag, pc and error-address sizes and their types

package ifu_geom_pkg;

   // ----------------------------------------
   // sizes
   // ----------------------------------------
   // hardware threads per core
   localparam int n_threads = 4;
   // icache associativity
   localparam int n_ways    = 4;
   // icache tag, parity bit included
   localparam int tag_w     = 28;
   // full virtual pc
   localparam int pc_w      = 48;
   // error address keeps pc bits 47..4
   localparam int ea_w      = 44;
   // one bit per instruction mask field
   localparam int imask_w   = 39;

   // ----------------------------------------
   // types
   // ----------------------------------------
   typedef logic [$clog2(n_threads)-1:0] thread_t;
   typedef logic [$clog2(n_ways)-1:0]    way_t;
   typedef logic [tag_w-1:0]             ic_tag_t;
   typedef logic [ea_w-1:0]              ea_t;
   typedef logic [pc_w-1:0]              pc_t;

endpackage
